// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_lf
FILELIST  ?= tb.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// ==== adc_sampler.sv ====
`default_nettype none

module adc_sampler
	import lf_pkg::*;
#(
	parameter int ADC_CLK_DIV = 10
) (
	input  logic      clk,
	input  logic      reset,
	output logic      adc_cs,
	output logic      adc_sclk,
	output logic      adc_din,
	input  logic      adc_dout,
	sensor_if.source  sense
);

	localparam int DIV_W = $clog2(ADC_CLK_DIV + 1);

	logic [DIV_W-1:0]    div_cnt;
	logic                tick;
	logic                rise;
	logic                fall;
	logic [3:0]          period;
	logic [3:0]          next_period;
	logic [1:0]          addr_sel;
	logic [1:0]          conv_sel;
	logic [2:0]          addr_ch;
	logic                frame_end;
	logic [SAMPLE_W-2:0] shift_reg;

	assign tick        = (div_cnt == DIV_W'(ADC_CLK_DIV - 1));
	assign rise        = tick && !adc_sclk;
	assign fall        = tick && adc_sclk;
	assign next_period = adc_cs ? 4'd0 : period + 4'd1;
	// Last data bit of the frame is on the wire
	assign frame_end   = rise && !adc_cs && (period == 4'd15);

	always_comb
	begin
		case (addr_sel)
			2'd0:    addr_ch = CH_LEFT;
			2'd1:    addr_ch = CH_CENTER;
			default: addr_ch = CH_RIGHT;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Serial clock, chip select and address out

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			div_cnt  <= '0;
			adc_sclk <= 1'b0;
			adc_cs   <= 1'b1;
			adc_din  <= 1'b0;
			period   <= 4'd0;
			addr_sel <= 2'd0;
			conv_sel <= 2'd0;
			sense.valid <= 1'b0;
		end
		else
		begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick)
				adc_sclk <= !adc_sclk;
			if (fall)
			begin
				adc_cs <= 1'b0;
				period <= next_period;
				case (next_period)
					4'd2:    adc_din <= addr_ch[2];
					4'd3:    adc_din <= addr_ch[1];
					4'd4:    adc_din <= addr_ch[0];
					default: adc_din <= 1'b0;
				endcase
			end
			sense.valid <= frame_end && (conv_sel == 2'd2);
			// Next frame converts what this frame addressed
			if (frame_end)
			begin
				conv_sel <= addr_sel;
				addr_sel <= (addr_sel == 2'd2) ? 2'd0 : addr_sel + 2'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sample capture

	always_ff @(posedge clk)
	begin
		if (rise && !adc_cs && period >= 4'd4)
			shift_reg <= {shift_reg[SAMPLE_W-3:0], adc_dout};
		if (frame_end)
		begin
			case (conv_sel)
				2'd0:    sense.left <= {shift_reg, adc_dout};
				2'd1:    sense.center <= {shift_reg, adc_dout};
				default: sense.right <= {shift_reg, adc_dout};
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== drive_if.sv ====
`default_nettype none

// Duty levels of the four wheel pins
interface drive_if
	import lf_pkg::*;
();
	logic [DUTY_W-1:0] rw_f;
	logic [DUTY_W-1:0] rw_b;
	logic [DUTY_W-1:0] lw_f;
	logic [DUTY_W-1:0] lw_b;

	modport source (output rw_f, output rw_b, output lw_f, output lw_b);
	modport sink (input rw_f, input rw_b, input lw_f, input lw_b);

endinterface

`default_nettype wire

// ==== lf_assertions.sv ====
`default_nettype none

module lf_assertions (
	input wire logic clk,
	input wire logic reset,
	input wire logic req,
	input wire logic ack,
	input wire logic adc_cs,
	input wire logic adc_sclk,
	input wire logic adc_din,
	input wire logic rw_f,
	input wire logic rw_b,
	input wire logic lw_f,
	input wire logic lw_b
);
	timeunit 1ns;
	timeprecision 100ps;

	logic       sclk_q;
	logic [3:0] per_q;
	logic [3:0] per;

	// Serial clock period of the frame, stepped on each falling edge
	assign per = (sclk_q && !adc_sclk) ? per_q + 4'd1 : per_q;

	always_ff @(posedge clk)
	begin
		sclk_q <= adc_sclk;
		if (reset || adc_cs)
			per_q <= 4'd15;
		else
			per_q <= per;
	end

	// Four-phase motion handshake
	a_req_held: assert property (@(posedge clk) disable iff (reset) req && !ack |=> req)
		else $error("req dropped before ack");
	a_ack_after_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req))
		else $error("ack rose without req");

	a_right_wheel: assert property (@(posedge clk) disable iff (reset) !(rw_f && rw_b))
		else $error("right wheel driven both ways");
	a_left_wheel: assert property (@(posedge clk) disable iff (reset) !(lw_f && lw_b))
		else $error("left wheel driven both ways");

	// Address bits only in periods 2 to 4, changed on falling serial clock
	a_din_addr_only: assert property (@(posedge clk) disable iff (reset)
		(per < 4'd2 || per > 4'd4) |-> !adc_din)
		else $error("adc_din high outside the address periods");
	a_din_on_fall: assert property (@(posedge clk) disable iff (reset)
		$changed(adc_din) |-> $fell(adc_sclk))
		else $error("adc_din changed away from a falling edge");

endmodule

`default_nettype wire

// ==== lf_pkg.sv ====
`default_nettype none

package lf_pkg;

	// ADC sample format
	localparam int SAMPLE_W = 12;
	typedef logic [SAMPLE_W-1:0] sample_t;

	// ADC channels of the reflectance sensors
	localparam logic [2:0] CH_LEFT   = 3'd5;
	localparam logic [2:0] CH_CENTER = 3'd6;
	localparam logic [2:0] CH_RIGHT  = 3'd7;

	// Wheel duty levels, in PWM steps
	localparam int DUTY_W    = 4;
	localparam int PWM_STEPS = 8;
	localparam logic [DUTY_W-1:0] DUTY_OFF  = 4'd0;
	localparam logic [DUTY_W-1:0] DUTY_SLOW = 4'd3;
	localparam logic [DUTY_W-1:0] DUTY_FAST = 4'd6;
	localparam logic [DUTY_W-1:0] DUTY_FULL = 4'd8;

	typedef enum logic [2:0] {
		MOVE_STOP,
		MOVE_FORWARD,
		VEER_RIGHT,
		VEER_LEFT,
		TURN_RIGHT,
		TURN_LEFT,
		TURN_ROUND,
		MOVE_HALT
	} motion_t;

endpackage

`default_nettype wire

// ==== lf_top.sv ====
`default_nettype none

module lf_top
	import lf_pkg::*;
#(
	parameter int ADC_CLK_DIV     = 10,
	parameter int WHITE_THRESHOLD = 2000,
	parameter int DEBOUNCE        = 20,
	parameter int MOVE_CYCLES     = 100000,
	parameter int BACKUP_CYCLES   = 10000000,
	parameter int TURN_CYCLES     = 25000000,
	parameter int ROUND_CYCLES    = 50000000,
	parameter int PWM_PRESCALE    = 1
) (
	input  logic       clk,
	input  logic       reset,
	output logic       adc_cs,
	output logic       adc_sclk,
	output logic       adc_din,
	input  logic       adc_dout,
	output logic       rw_f,
	output logic       rw_b,
	output logic       lw_f,
	output logic       lw_b,
	output logic       led_l,
	output logic       led_m,
	output logic       led_r,
	output logic [3:0] digit
);

	sensor_if sense();
	drive_if  drive();

	logic    req;
	logic    ack;
	motion_t cmd;

	adc_sampler #(
		.ADC_CLK_DIV(ADC_CLK_DIV)
	) i_sampler (
		.clk     (clk),
		.reset   (reset),
		.adc_cs  (adc_cs),
		.adc_sclk(adc_sclk),
		.adc_din (adc_din),
		.adc_dout(adc_dout),
		.sense   (sense.source)
	);

	line_decoder #(
		.WHITE_THRESHOLD(WHITE_THRESHOLD),
		.DEBOUNCE       (DEBOUNCE)
	) i_decoder (
		.clk  (clk),
		.reset(reset),
		.sense(sense.sink),
		.req  (req),
		.ack  (ack),
		.cmd  (cmd),
		.led_l(led_l),
		.led_m(led_m),
		.led_r(led_r),
		.digit(digit)
	);

	motion_executor #(
		.MOVE_CYCLES  (MOVE_CYCLES),
		.BACKUP_CYCLES(BACKUP_CYCLES),
		.TURN_CYCLES  (TURN_CYCLES),
		.ROUND_CYCLES (ROUND_CYCLES)
	) i_executor (
		.clk  (clk),
		.reset(reset),
		.req  (req),
		.cmd  (cmd),
		.ack  (ack),
		.drive(drive.source)
	);

	wheel_pwm #(
		.PWM_PRESCALE(PWM_PRESCALE)
	) i_pwm (
		.clk  (clk),
		.reset(reset),
		.drive(drive.sink),
		.rw_f (rw_f),
		.rw_b (rw_b),
		.lw_f (lw_f),
		.lw_b (lw_b)
	);

endmodule

`default_nettype wire

// ==== line_decoder.sv ====
`default_nettype none

module line_decoder
	import lf_pkg::*;
#(
	parameter int WHITE_THRESHOLD = 2000,
	parameter int DEBOUNCE        = 20
) (
	input  logic       clk,
	input  logic       reset,
	sensor_if.sink     sense,
	output logic       req,
	input  logic       ack,
	output motion_t    cmd,
	output logic       led_l,
	output logic       led_m,
	output logic       led_r,
	output logic [3:0] digit
);

	localparam int CNT_W = $clog2(DEBOUNCE + 1);
	localparam sample_t THRESH = sample_t'(WHITE_THRESHOLD);

	logic [2:0]       pat;
	logic [2:0]       last_pat;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;
	logic [3:0]       route_idx;
	logic             at_junction;
	logic             halted;

	// Fixed route taken at successive junctions
	function automatic motion_t route_step(input logic [3:0] idx);
		case (idx)
			4'd0:             return TURN_RIGHT;
			4'd2, 4'd6:       return TURN_ROUND;
			4'd1, 4'd3, 4'd4,
			4'd5, 4'd7, 4'd8: return TURN_LEFT;
			default:          return MOVE_HALT;
		endcase
	endfunction

	function automatic motion_t pattern_cmd(input logic [2:0] p, input motion_t junction);
		case (p)
			3'b000, 3'b101: return MOVE_STOP;
			3'b001, 3'b011: return VEER_RIGHT;
			3'b010:         return MOVE_FORWARD;
			3'b100, 3'b110: return VEER_LEFT;
			default:        return junction;
		endcase
	endfunction

	// Dark is 1, weighted L=4 C=2 R=1
	assign pat = {sense.left > THRESH, sense.center > THRESH, sense.right > THRESH};
	assign cnt_next = (cnt != '0 && pat == last_pat) ? cnt + 1'b1 : CNT_W'(1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			req         <= 1'b0;
			cmd         <= MOVE_STOP;
			digit       <= 4'd0;
			led_l       <= 1'b0;
			led_m       <= 1'b0;
			led_r       <= 1'b0;
			last_pat    <= 3'b000;
			cnt         <= '0;
			route_idx   <= 4'd0;
			at_junction <= 1'b0;
			halted      <= 1'b0;
		end
		else
		begin
			if (sense.valid)
			begin
				led_l <= !pat[2];
				led_m <= !pat[1];
				led_r <= !pat[0];
			end
			if (req && ack)
			begin
				req   <= 1'b0;
				digit <= 4'd0;
				if (at_junction)
					route_idx <= route_idx + 4'd1;
				if (cmd == MOVE_HALT)
					halted <= 1'b1;
			end
			// Triples are dropped while a motion is in flight
			else if (sense.valid && !req && !ack && !halted)
			begin
				last_pat <= pat;
				if (cnt_next == CNT_W'(DEBOUNCE))
				begin
					req         <= 1'b1;
					cmd         <= pattern_cmd(pat, route_step(route_idx));
					digit       <= {1'b0, pat} + 4'd1;
					at_junction <= (pat == 3'b111);
					cnt         <= '0;
				end
				else
					cnt <= cnt_next;
			end
		end
	end

endmodule

`default_nettype wire

// ==== motion_executor.sv ====
`default_nettype none

module motion_executor
	import lf_pkg::*;
#(
	parameter int MOVE_CYCLES   = 100000,
	parameter int BACKUP_CYCLES = 10000000,
	parameter int TURN_CYCLES   = 25000000,
	parameter int ROUND_CYCLES  = 50000000
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     req,
	input  motion_t  cmd,
	output logic     ack,
	drive_if.source  drive
);

	localparam int MAX_MR = (MOVE_CYCLES > ROUND_CYCLES) ? MOVE_CYCLES : ROUND_CYCLES;
	localparam int MAX_BT = (BACKUP_CYCLES > TURN_CYCLES) ? BACKUP_CYCLES : TURN_CYCLES;
	localparam int CNT_W  = $clog2(((MAX_MR > MAX_BT) ? MAX_MR : MAX_BT) + 1);

	typedef enum logic [1:0] {IDLE, BACKUP, RUN, DONE} state_t;

	state_t           state;
	motion_t          cur;
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			cur   <= MOVE_STOP;
			cnt   <= '0;
			ack   <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (req)
					begin
						cur <= cmd;
						case (cmd)
							MOVE_FORWARD, VEER_RIGHT, VEER_LEFT:
							begin
								state <= RUN;
								cnt   <= CNT_W'(MOVE_CYCLES - 1);
							end
							TURN_RIGHT, TURN_LEFT:
							begin
								state <= BACKUP;
								cnt   <= CNT_W'(BACKUP_CYCLES - 1);
							end
							TURN_ROUND:
							begin
								state <= RUN;
								cnt   <= CNT_W'(ROUND_CYCLES - 1);
							end
							// Stop and halt finish at once
							default:
							begin
								state <= DONE;
								ack   <= 1'b1;
							end
						endcase
					end
				BACKUP:
					if (cnt == '0)
					begin
						state <= RUN;
						cnt   <= CNT_W'(TURN_CYCLES - 1);
					end
					else
						cnt <= cnt - 1'b1;
				RUN:
					if (cnt == '0)
					begin
						state <= DONE;
						ack   <= 1'b1;
					end
					else
						cnt <= cnt - 1'b1;
				DONE:
					if (!req)
					begin
						state <= IDLE;
						ack   <= 1'b0;
					end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Wheel duties per phase

	always_comb
	begin
		drive.rw_f = DUTY_OFF;
		drive.rw_b = DUTY_OFF;
		drive.lw_f = DUTY_OFF;
		drive.lw_b = DUTY_OFF;
		if (state == BACKUP)
		begin
			drive.rw_b = DUTY_FULL;
			drive.lw_b = DUTY_FULL;
		end
		else if (state == RUN)
		begin
			case (cur)
				MOVE_FORWARD:
				begin
					drive.rw_f = DUTY_FAST;
					drive.lw_f = DUTY_FAST;
				end
				VEER_RIGHT:
				begin
					drive.lw_f = DUTY_FAST;
					drive.rw_b = DUTY_SLOW;
				end
				VEER_LEFT:
				begin
					drive.rw_f = DUTY_FAST;
					drive.lw_b = DUTY_SLOW;
				end
				TURN_RIGHT, TURN_ROUND:
				begin
					drive.rw_f = DUTY_FULL;
					drive.lw_b = DUTY_FULL;
				end
				TURN_LEFT:
				begin
					drive.rw_b = DUTY_FULL;
					drive.lw_f = DUTY_FULL;
				end
				default:
				begin
					drive.rw_f = DUTY_OFF;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== sensor_if.sv ====
`default_nettype none

// Latest left, center and right readings
interface sensor_if
	import lf_pkg::*;
();
	sample_t left;
	sample_t center;
	sample_t right;
	logic    valid;

	modport source (output left, output center, output right, output valid);
	modport sink (input left, input center, input right, input valid);

endinterface

`default_nettype wire

// ==== tb.f ====
lf_pkg.sv
sensor_if.sv
drive_if.sv
adc_sampler.sv
line_decoder.sv
motion_executor.sv
wheel_pwm.sv
lf_top.sv
lf_assertions.sv
tb_lf.sv

// ==== tb_lf.sv ====
`default_nettype none

module tb_lf
	import lf_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int THRESH = 2000;
	localparam logic [11:0] W = 12'd1000;
	localparam logic [11:0] D = 12'd3000;
	// Roughly 22000 cycles of tests, doubled
	localparam int TIMEOUT_CYCLES = 45000;

	logic       clk;
	logic       reset;
	logic       adc_cs;
	logic       adc_sclk;
	logic       adc_din;
	logic       adc_dout;
	logic       rw_f;
	logic       rw_b;
	logic       lw_f;
	logic       lw_b;
	logic       led_l;
	logic       led_m;
	logic       led_r;
	logic [3:0] digit;

	logic [11:0] val_l;
	logic [11:0] val_c;
	logic [11:0] val_r;
	int          cycles;
	int          triple_cnt;
	logic [2:0]  addr_log[$];
	int          win_n;
	int          hi_cnt[4];
	logic [3:0]  pin_mask;

	lf_top #(
		.ADC_CLK_DIV    (2),
		.WHITE_THRESHOLD(THRESH),
		.DEBOUNCE       (3),
		.MOVE_CYCLES    (64),
		.BACKUP_CYCLES  (32),
		.TURN_CYCLES    (48),
		.ROUND_CYCLES   (64),
		.PWM_PRESCALE   (1)
	) i_dut (
		.clk(clk), .reset(reset),
		.adc_cs(adc_cs), .adc_sclk(adc_sclk), .adc_din(adc_din), .adc_dout(adc_dout),
		.rw_f(rw_f), .rw_b(rw_b), .lw_f(lw_f), .lw_b(lw_b),
		.led_l(led_l), .led_m(led_m), .led_r(led_r), .digit(digit)
	);

	bind lf_top lf_assertions i_assertions (
		.clk(clk), .reset(reset), .req(req), .ack(ack),
		.adc_cs(adc_cs), .adc_sclk(adc_sclk), .adc_din(adc_din),
		.rw_f(rw_f), .rw_b(rw_b), .lw_f(lw_f), .lw_b(lw_b)
	);

	always #5 clk = !clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the DUT did not respond within the cycle limit");
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ADC model

	function automatic logic [11:0] ch_value(input logic [2:0] ch);
		case (ch)
			CH_LEFT:   return val_l;
			CH_CENTER: return val_c;
			default:   return val_r;
		endcase
	endfunction

	int          per;
	int          next_per;
	logic [2:0]  addr;
	logic [2:0]  conv_ch;
	logic [2:0]  prev_addr;
	logic [11:0] conv_word;

	// Works on the serial clock rise, then sets up data for the next period
	always @(posedge adc_sclk)
	begin
		#2;
		if (adc_cs)
		begin
			next_per = 0;
			adc_dout = 1'b0;
		end
		else
		begin
			per = next_per;
			next_per = (per + 1) % 16;
			if (per >= 2 && per <= 4)
				addr = {addr[1:0], adc_din};
			if (per == 4)
				addr_log.push_back(addr);
			if (per == 3)
			begin
				conv_ch = prev_addr;
				conv_word = ch_value(conv_ch);
			end
			if (per >= 3 && per <= 14)
				adc_dout = conv_word[14-per];
			else
				adc_dout = 1'b0;
			if (per == 15)
			begin
				prev_addr = addr;
				if (conv_ch == CH_RIGHT)
					triple_cnt++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic wait_triples(input int n, input bit quiet);
		int target;
		target = triple_cnt + n;
		while (triple_cnt < target)
		begin
			@(posedge clk);
			#1;
			if (quiet)
			begin
				check_eq("digit", digit, 0);
				check_eq("wheel pins", {lw_b, lw_f, rw_b, rw_f}, 0);
			end
		end
	endtask

	task automatic set_sensors(input logic [11:0] l, input logic [11:0] c, input logic [11:0] r);
		val_l = l;
		val_c = c;
		val_r = r;
	endtask

	task automatic check_leds(input logic [11:0] l, input logic [11:0] c, input logic [11:0] r);
		set_sensors(l, c, r);
		wait_triples(2, 1'b0);
		check_eq("led_l", led_l, l <= THRESH);
		check_eq("led_m", led_m, c <= THRESH);
		check_eq("led_r", led_r, r <= THRESH);
	endtask

	// Counts pin activity while a motion is shown on digit
	task automatic measure_motion();
		win_n = 0;
		pin_mask = '0;
		for (int i = 0; i < 4; i++)
			hi_cnt[i] = 0;
		while (digit != 0)
		begin
			win_n++;
			hi_cnt[0] += rw_f;
			hi_cnt[1] += rw_b;
			hi_cnt[2] += lw_f;
			hi_cnt[3] += lw_b;
			pin_mask |= {lw_b, lw_f, rw_b, rw_f};
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_motion(input logic [11:0] l, input logic [11:0] c, input logic [11:0] r,
			input int exp_digit, input logic [3:0] exp_mask);
		while (digit != 0)
			@(posedge clk);
		#1;
		set_sensors(l, c, r);
		while (digit == 0)
		begin
			@(posedge clk);
			#1;
		end
		check_eq("digit", digit, exp_digit);
		measure_motion();
		check_eq("wheel pin set", pin_mask, exp_mask);
	endtask

	task automatic check_duty(input int idx, input string name, input int duty);
		int exp;
		int err;
		exp = win_n * duty / PWM_STEPS;
		err = hi_cnt[idx] - exp;
		if (err < 0)
			err = -err;
		check_eq(name, hi_cnt[idx], (err <= PWM_STEPS) ? hi_cnt[idx] : exp);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_and_adc();
		check_eq("adc_cs", adc_cs, 1);
		check_eq("adc_sclk", adc_sclk, 0);
		check_eq("adc_din", adc_din, 0);
		check_eq("digit", digit, 0);
		check_eq("wheel pins", {lw_b, lw_f, rw_b, rw_f}, 0);
		check_eq("leds", {led_l, led_m, led_r}, 0);
		wait_triples(2, 1'b0);
		if (addr_log.size() < 4)
			fail_run("The ADC model saw too few addresses");
		check_eq("address 0", addr_log[0], CH_LEFT);
		check_eq("address 1", addr_log[1], CH_CENTER);
		check_eq("address 2", addr_log[2], CH_RIGHT);
		check_eq("address 3", addr_log[3], CH_LEFT);
		check_leds(12'd2000, 12'd2001, 12'd4095);
	endtask

	task automatic test_follow();
		run_motion(W, D, W, 3, 4'b0101);
		check_duty(0, "rw_f high cycles", 6);
		check_duty(2, "lw_f high cycles", 6);
		run_motion(W, W, D, 2, 4'b0110);
		check_duty(2, "lw_f high cycles", 6);
		check_duty(1, "rw_b high cycles", 3);
		run_motion(D, W, W, 5, 4'b1001);
		check_duty(0, "rw_f high cycles", 6);
		check_duty(3, "lw_b high cycles", 3);
	endtask

	task automatic test_stop_patterns();
		run_motion(W, W, W, 1, 4'b0000);
		run_motion(D, W, D, 6, 4'b0000);
	endtask

	task automatic test_short_pattern();
		while (digit != 0)
			@(posedge clk);
		wait_triples(1, 1'b0);
		for (int i = 0; i < 2; i++)
		begin
			set_sensors(W, D, W);
			wait_triples(2, 1'b1);
			set_sensors(D, D, W);
			wait_triples(2, 1'b1);
		end
	endtask

	task automatic test_route();
		logic [3:0] route_mask[10];
		route_mask = '{4'b1011, 4'b1110, 4'b1001, 4'b1110, 4'b1110,
			4'b1110, 4'b1001, 4'b1110, 4'b1110, 4'b0000};
		for (int i = 0; i < 10; i++)
		begin
			run_motion(D, D, D, 8, route_mask[i]);
			// Short white gap, below the debounce length
			set_sensors(W, W, W);
			wait_triples(1, 1'b0);
		end
		set_sensors(D, D, D);
		wait_triples(6, 1'b1);
		check_leds(W, D, W);
		check_leds(D, W, D);
		check_eq("digit", digit, 0);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		adc_dout = 1'b0;
		cycles = 0;
		triple_cnt = 0;
		prev_addr = CH_LEFT;
		conv_ch = CH_LEFT;
		addr = '0;
		conv_word = '0;
		next_per = 0;
		set_sensors(12'd2001, 12'd2000, 12'd4095);
		repeat (5)
			@(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_and_adc();
		test_follow();
		test_stop_patterns();
		test_short_pattern();
		test_route();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== wheel_pwm.sv ====
`default_nettype none

module wheel_pwm
	import lf_pkg::*;
#(
	parameter int PWM_PRESCALE = 1
) (
	input  logic   clk,
	input  logic   reset,
	drive_if.sink  drive,
	output logic   rw_f,
	output logic   rw_b,
	output logic   lw_f,
	output logic   lw_b
);

	localparam int PRE_W  = $clog2(PWM_PRESCALE + 1);
	localparam int STEP_W = $clog2(PWM_STEPS);

	logic [PRE_W-1:0]  pre_cnt;
	logic [STEP_W-1:0] step;
	logic [DUTY_W-1:0] step_ext;
	logic              pre_end;

	assign pre_end  = (pre_cnt == PRE_W'(PWM_PRESCALE - 1));
	assign step_ext = DUTY_W'(step);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pre_cnt <= '0;
			step    <= '0;
			rw_f    <= 1'b0;
			rw_b    <= 1'b0;
			lw_f    <= 1'b0;
			lw_b    <= 1'b0;
		end
		else
		begin
			pre_cnt <= pre_end ? '0 : pre_cnt + 1'b1;
			if (pre_end)
				step <= (step == STEP_W'(PWM_STEPS - 1)) ? '0 : step + 1'b1;
			// Pin high while the step is below its duty
			rw_f <= step_ext < drive.rw_f;
			rw_b <= step_ext < drive.rw_b;
			lw_f <= step_ext < drive.lw_f;
			lw_b <= step_ext < drive.lw_b;
		end
	end

endmodule

`default_nettype wire
